// File: verilog/icache_pkg.sv
//----------------------------------------------------------------------
// geometry, address fields and stored entry types of the instruction
// cache, referred to by scoped name from every cache module.
//----------------------------------------------------------------------
`default_nettype none

package icache_pkg;

    localparam int ADDR_W   = 32;
    localparam int INST_W   = 32;
    localparam int LINE_W   = 2 * INST_W;
    localparam int NUM_SETS = 64;
    localparam int INDEX_W  = $clog2(NUM_SETS);
    localparam int TAG_W    = ADDR_W - INDEX_W - $clog2(LINE_W / 8);

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [INST_W-1:0]  inst_t;
    typedef logic [LINE_W-1:0]  line_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic               way_t;

    // a fetch address split into its cache fields.
    typedef struct packed {
        tag_t       tag;
        index_t     index;
        logic       word;
        logic [1:0] byte_off;
    } addr_fields_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    // one line write into the data arrays, seen also by the LRU logic.
    typedef struct packed {
        logic   we;
        way_t   way;
        index_t index;
        line_t  line;
    } fill_t;

    typedef enum logic [2:0] {
        ST_FLUSH,
        ST_IDLE,
        ST_LOOKUP,
        ST_COMPARE,
        ST_REFILL,
        ST_FILL
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: verilog/icache_sram.sv
//----------------------------------------------------------------------
// single port storage array, one access per cycle with registered
// read data; the entry type is set by the instantiating module.
//----------------------------------------------------------------------
`default_nettype none

module icache_sram #(
    parameter int  DEPTH   = 64,
    parameter type entry_t = logic
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] addr_i,
    input  logic                     we_i,
    input  entry_t                   wdata_i,
    output entry_t                   rdata_o
);

    entry_t mem [DEPTH];

    // a write also shows up on the read port in the next cycle, so the
    // controller can look up a line right after it was filled.
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
            rdata_o     <= wdata_i;
        end else begin
            rdata_o <= mem[addr_i];
        end
    end

endmodule

`default_nettype wire

// File: verilog/icache_lookup.sv
//----------------------------------------------------------------------
// hit test on both ways and instruction select from the hit line.
//----------------------------------------------------------------------
`default_nettype none

module icache_lookup (
    input  icache_pkg::tag_entry_t tag0_i,
    input  icache_pkg::tag_entry_t tag1_i,
    input  icache_pkg::line_t      line0_i,
    input  icache_pkg::line_t      line1_i,
    input  icache_pkg::addr_t      addr_i,
    output logic                   hit_o,
    output icache_pkg::way_t       hit_way_o,
    output icache_pkg::inst_t      inst_o
);

    icache_pkg::addr_fields_t addr_f;
    icache_pkg::line_t        sel_line;
    logic                     hit0;
    logic                     hit1;

    assign addr_f = addr_i;

    assign hit0 = tag0_i.valid && (tag0_i.tag == addr_f.tag);
    assign hit1 = tag1_i.valid && (tag1_i.tag == addr_f.tag);

    assign hit_o = hit0 || hit1;

    // way 0 takes precedence should both ways ever match.
    assign hit_way_o = hit0 ? 1'b0 : 1'b1;

    always_comb begin
        if (hit_way_o) begin
            sel_line = line1_i;
        end else begin
            sel_line = line0_i;
        end
    end

    // bit 2 of the address picks the upper or lower instruction.
    always_comb begin
        if (addr_f.word) begin
            inst_o = sel_line[2*icache_pkg::INST_W-1:icache_pkg::INST_W];
        end else begin
            inst_o = sel_line[icache_pkg::INST_W-1:0];
        end
    end

endmodule

`default_nettype wire

// File: verilog/icache_replace.sv
//----------------------------------------------------------------------
// per set LRU bit and victim choice for the two way cache. the victim
// is valid for the index presented by the controller.
//----------------------------------------------------------------------
`default_nettype none

module icache_replace #(
    parameter int DEPTH = icache_pkg::NUM_SETS
) (
    input  logic               clk,
    input  logic               rst_n_i,
    input  icache_pkg::index_t index_i,
    input  logic               valid0_i,
    input  logic               valid1_i,
    input  logic               touch_i,
    input  icache_pkg::way_t   touch_way_i,
    input  icache_pkg::fill_t  fill_i,
    output icache_pkg::way_t   victim_o
);

    // lru_q names, per set, the way that was used less recently.
    logic [DEPTH-1:0] lru_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            lru_q <= '0;
        end else if (fill_i.we) begin
            lru_q[fill_i.index] <= ~fill_i.way;
        end else if (touch_i) begin
            lru_q[index_i] <= ~touch_way_i;
        end
    end

    // an empty way is always taken first, way 0 before way 1.
    always_comb begin
        if (!valid0_i) begin
            victim_o = 1'b0;
        end else if (!valid1_i) begin
            victim_o = 1'b1;
        end else begin
            victim_o = lru_q[index_i];
        end
    end

endmodule

`default_nettype wire

// File: verilog/icache_ctrl.sv
//----------------------------------------------------------------------
// cache FSM: request capture, lookup, refill, line write and the
// invalidation walk after reset or fence; drives all array ports.
//----------------------------------------------------------------------
`default_nettype none

module icache_ctrl #(
    parameter int DEPTH = icache_pkg::NUM_SETS
) (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   req_valid_i,
    input  icache_pkg::addr_t      req_addr_i,
    input  logic                   fence_i,
    output logic                   ready_o,
    output logic                   resp_valid_o,
    output icache_pkg::inst_t      resp_inst_o,
    output logic                   mem_req_o,
    output icache_pkg::addr_t      mem_addr_o,
    input  logic                   mem_resp_valid_i,
    input  icache_pkg::line_t      mem_resp_line_i,
    input  logic                   hit_i,
    input  icache_pkg::way_t       hit_way_i,
    input  icache_pkg::inst_t      hit_inst_i,
    input  icache_pkg::way_t       victim_i,
    output icache_pkg::index_t     array_index_o,
    output icache_pkg::fill_t      fill_o,
    output logic [1:0]             tag_we_o,
    output icache_pkg::tag_entry_t tag_wdata_o,
    output logic                   touch_o,
    output icache_pkg::way_t       touch_way_o,
    output icache_pkg::addr_t      held_addr_o
);

    localparam int CNT_W = $clog2(DEPTH);

    icache_pkg::ctrl_state_t  state_q;
    icache_pkg::ctrl_state_t  state_d;
    logic [CNT_W-1:0]         flush_cnt_q;
    icache_pkg::addr_t        held_addr_q;
    icache_pkg::addr_fields_t req_f;
    icache_pkg::addr_fields_t held_f;
    icache_pkg::line_t        line_q;
    logic                     hit_q;
    logic                     flush_done;
    logic                     accept;
    logic                     lookup_hit;

    assign req_f = req_addr_i;
    assign held_f = held_addr_q;

    assign flush_done = (flush_cnt_q == CNT_W'(DEPTH - 1));
    // a fence in the same cycle wins over a fetch.
    assign accept = (state_q == icache_pkg::ST_IDLE) && req_valid_i && !fence_i;
    assign lookup_hit = (state_q == icache_pkg::ST_LOOKUP) && hit_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            icache_pkg::ST_FLUSH: begin
                if (flush_done) begin
                    state_d = icache_pkg::ST_IDLE;
                end
            end
            icache_pkg::ST_IDLE: begin
                if (fence_i) begin
                    state_d = icache_pkg::ST_FLUSH;
                end else if (req_valid_i) begin
                    state_d = icache_pkg::ST_LOOKUP;
                end
            end
            icache_pkg::ST_LOOKUP: begin
                state_d = icache_pkg::ST_COMPARE;
            end
            icache_pkg::ST_COMPARE: begin
                if (hit_q) begin
                    state_d = icache_pkg::ST_IDLE;
                end else begin
                    state_d = icache_pkg::ST_REFILL;
                end
            end
            icache_pkg::ST_REFILL: begin
                if (mem_resp_valid_i) begin
                    state_d = icache_pkg::ST_FILL;
                end
            end
            icache_pkg::ST_FILL: begin
                state_d = icache_pkg::ST_LOOKUP;
            end
            default: begin
                state_d = icache_pkg::ST_FLUSH;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q      <= icache_pkg::ST_FLUSH;
            flush_cnt_q  <= '0;
            hit_q        <= 1'b0;
            resp_valid_o <= 1'b0;
        end else begin
            state_q      <= state_d;
            resp_valid_o <= lookup_hit;
            if (state_q == icache_pkg::ST_FLUSH) begin
                flush_cnt_q <= flush_cnt_q + 1'b1;
            end else begin
                flush_cnt_q <= '0;
            end
            if (state_q == icache_pkg::ST_LOOKUP) begin
                hit_q <= hit_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held_addr_q <= req_addr_i;
        end
        if ((state_q == icache_pkg::ST_REFILL) && mem_resp_valid_i) begin
            line_q <= mem_resp_line_i;
        end
        if (lookup_hit) begin
            resp_inst_o <= hit_inst_i;
        end
    end

    assign ready_o = (state_q == icache_pkg::ST_IDLE);
    assign mem_req_o = (state_q == icache_pkg::ST_REFILL);
    assign mem_addr_o = {held_f.tag, held_f.index, 3'b000};
    assign held_addr_o = held_addr_q;

    // in idle the arrays already read the set of the incoming request.
    always_comb begin
        case (state_q)
            icache_pkg::ST_FLUSH: array_index_o = icache_pkg::index_t'(flush_cnt_q);
            icache_pkg::ST_IDLE:  array_index_o = req_f.index;
            default:              array_index_o = held_f.index;
        endcase
    end

    always_comb begin
        case (state_q)
            icache_pkg::ST_FLUSH: tag_we_o = 2'b11;
            icache_pkg::ST_FILL:  tag_we_o = {victim_i, ~victim_i};
            default:              tag_we_o = 2'b00;
        endcase
        tag_wdata_o.valid = (state_q == icache_pkg::ST_FILL);
        tag_wdata_o.tag   = held_f.tag;
    end

    always_comb begin
        fill_o.we    = (state_q == icache_pkg::ST_FILL);
        fill_o.way   = victim_i;
        fill_o.index = held_f.index;
        fill_o.line  = line_q;
    end

    assign touch_o = lookup_hit;
    assign touch_way_o = hit_way_i;

endmodule

`default_nettype wire

// File: verilog/icache_top.sv
//----------------------------------------------------------------------
// two way instruction cache top level; SETS sizes the arrays and the
// LRU state and must be a power of two.
//----------------------------------------------------------------------
`default_nettype none

module icache_top #(
    parameter int SETS = icache_pkg::NUM_SETS
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              req_valid_i,
    input  icache_pkg::addr_t req_addr_i,
    input  logic              fence_i,
    output logic              ready_o,
    output logic              resp_valid_o,
    output icache_pkg::inst_t resp_inst_o,
    output logic              mem_req_o,
    output icache_pkg::addr_t mem_addr_o,
    input  logic              mem_resp_valid_i,
    input  icache_pkg::line_t mem_resp_line_i
);

    icache_pkg::index_t       array_index;
    icache_pkg::fill_t        fill;
    logic [1:0]               tag_we;
    icache_pkg::tag_entry_t   tag_wdata;
    icache_pkg::tag_entry_t   tag_rdata [2];
    icache_pkg::line_t        line_rdata [2];
    logic                     hit;
    icache_pkg::way_t         hit_way;
    icache_pkg::inst_t        hit_inst;
    icache_pkg::way_t         victim;
    logic                     touch;
    icache_pkg::way_t         touch_way;
    icache_pkg::addr_t        held_addr;
    icache_pkg::addr_fields_t held_f;

    assign held_f = held_addr;

    icache_ctrl #(
        .DEPTH (SETS)
    ) u_ctrl (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .req_valid_i      (req_valid_i),
        .req_addr_i       (req_addr_i),
        .fence_i          (fence_i),
        .ready_o          (ready_o),
        .resp_valid_o     (resp_valid_o),
        .resp_inst_o      (resp_inst_o),
        .mem_req_o        (mem_req_o),
        .mem_addr_o       (mem_addr_o),
        .mem_resp_valid_i (mem_resp_valid_i),
        .mem_resp_line_i  (mem_resp_line_i),
        .hit_i            (hit),
        .hit_way_i        (hit_way),
        .hit_inst_i       (hit_inst),
        .victim_i         (victim),
        .array_index_o    (array_index),
        .fill_o           (fill),
        .tag_we_o         (tag_we),
        .tag_wdata_o      (tag_wdata),
        .touch_o          (touch),
        .touch_way_o      (touch_way),
        .held_addr_o      (held_addr)
    );

    // each way has its own tag array and data array on a shared index.
    for (genvar w = 0; w < 2; w++) begin : g_way
        icache_sram #(
            .DEPTH   (SETS),
            .entry_t (icache_pkg::tag_entry_t)
        ) u_tag (
            .clk     (clk),
            .addr_i  (array_index),
            .we_i    (tag_we[w]),
            .wdata_i (tag_wdata),
            .rdata_o (tag_rdata[w])
        );

        icache_sram #(
            .DEPTH   (SETS),
            .entry_t (icache_pkg::line_t)
        ) u_data (
            .clk     (clk),
            .addr_i  (array_index),
            .we_i    (fill.we && (fill.way == icache_pkg::way_t'(w))),
            .wdata_i (fill.line),
            .rdata_o (line_rdata[w])
        );
    end

    icache_lookup u_lookup (
        .tag0_i    (tag_rdata[0]),
        .tag1_i    (tag_rdata[1]),
        .line0_i   (line_rdata[0]),
        .line1_i   (line_rdata[1]),
        .addr_i    (held_addr),
        .hit_o     (hit),
        .hit_way_o (hit_way),
        .inst_o    (hit_inst)
    );

    icache_replace #(
        .DEPTH (SETS)
    ) u_replace (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .index_i     (held_f.index),
        .valid0_i    (tag_rdata[0].valid),
        .valid1_i    (tag_rdata[1].valid),
        .touch_i     (touch),
        .touch_way_i (touch_way),
        .fill_i      (fill),
        .victim_o    (victim)
    );

endmodule

`default_nettype wire

// File: sim/icache_props.sv
//----------------------------------------------------------------------
// handshake checks on the cache FSM, bound into every icache_ctrl.
//----------------------------------------------------------------------
`default_nettype none

module icache_props (
    input logic                    clk,
    input logic                    rst_n_i,
    input icache_pkg::ctrl_state_t state_i,
    input logic                    ready_i,
    input logic                    resp_valid_i,
    input logic                    mem_req_i,
    input icache_pkg::addr_t       mem_addr_i,
    input logic                    mem_resp_valid_i
);

    // the memory request holds with a stable address until data returns.
    a_mem_req_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_req_i && !mem_resp_valid_i |=> mem_req_i && $stable(mem_addr_i))
        else $error("mem_req_o dropped or mem_addr_o moved before mem_resp_valid_i");

    a_resp_single: assert property (@(posedge clk) disable iff (!rst_n_i)
        resp_valid_i |=> !resp_valid_i)
        else $error("resp_valid_o lasted more than one cycle");

    a_ready_vs_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(ready_i && mem_req_i))
        else $error("ready_o and mem_req_o high together");

    a_flush_quiet: assert property (@(posedge clk) disable iff (!rst_n_i)
        state_i == icache_pkg::ST_FLUSH |-> !ready_i && !mem_req_i && !resp_valid_i)
        else $error("output active during the invalidation walk");

endmodule

bind icache_ctrl icache_props u_props (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .state_i          (state_q),
    .ready_i          (ready_o),
    .resp_valid_i     (resp_valid_o),
    .mem_req_i        (mem_req_o),
    .mem_addr_i       (mem_addr_o),
    .mem_resp_valid_i (mem_resp_valid_i)
);

`default_nettype wire

// File: sim/icache_tb.sv
//----------------------------------------------------------------------
// self-checking testbench that drives LFSR chosen fetches and fences on
// the cache and checks them against a reference model and memory hash.
//----------------------------------------------------------------------
`default_nettype none

module icache_tb;

    localparam int SETS = icache_pkg::NUM_SETS;
    localparam int RESP_LIMIT = 64;

    logic              clk;
    logic              rst_n_i;
    logic              req_valid_i;
    icache_pkg::addr_t req_addr_i;
    logic              fence_i;
    logic              ready_o;
    logic              resp_valid_o;
    icache_pkg::inst_t resp_inst_o;
    logic              mem_req_o;
    icache_pkg::addr_t mem_addr_o;
    logic              mem_resp_valid_i = 1'b0;
    icache_pkg::line_t mem_resp_line_i = '0;

    logic [31:0] lfsr = 32'h68a3_32f1;
    int          mem_delay = 1;
    int          mem_wait = 0;
    int          err_count = 0;
    int          check_count = 0;
    logic        timed_out = 1'b0;
    int          dut_refills = 0;
    int          model_refills = 0;

    // the reference model keeps the valid bit and tag of each way and the older way per set.
    logic              m_valid [2][SETS];
    icache_pkg::tag_t  m_tag [2][SETS];
    logic              m_lru [SETS];

    icache_top #(
        .SETS (SETS)
    ) uut (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .req_valid_i      (req_valid_i),
        .req_addr_i       (req_addr_i),
        .fence_i          (fence_i),
        .ready_o          (ready_o),
        .resp_valid_o     (resp_valid_o),
        .resp_inst_o      (resp_inst_o),
        .mem_req_o        (mem_req_o),
        .mem_addr_o       (mem_addr_o),
        .mem_resp_valid_i (mem_resp_valid_i),
        .mem_resp_line_i  (mem_resp_line_i)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic rand_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
    endtask

    // memory content is a fixed hash of the word address.
    function automatic icache_pkg::inst_t mem_word(input icache_pkg::addr_t a);
        icache_pkg::inst_t h;
        h = a ^ 32'h5bd1_e995;
        h = h * 32'h2c1b_3c6d;
        return h ^ {h[15:0], h[31:16]};
    endfunction

    function automatic icache_pkg::line_t mem_line(input icache_pkg::addr_t a);
        icache_pkg::addr_t base;
        base = {a[31:3], 3'b000};
        return {mem_word(base + 32'd4), mem_word(base)};
    endfunction

    always @(posedge clk) begin
        if (!rst_n_i) begin
            mem_resp_valid_i <= 1'b0;
            mem_wait <= 0;
        end else if (mem_req_o && !mem_resp_valid_i) begin
            if (mem_wait + 1 >= mem_delay) begin
                mem_resp_valid_i <= 1'b1;
                mem_resp_line_i <= mem_line(mem_addr_o);
                mem_wait <= 0;
            end else begin
                mem_wait <= mem_wait + 1;
            end
        end else begin
            mem_resp_valid_i <= 1'b0;
        end
    end

    // every memory handshake counts as one refill of the DUT.
    always @(posedge clk) begin
        if (rst_n_i && mem_req_o && mem_resp_valid_i) begin
            dut_refills++;
        end
    end

    task automatic check_inst(input string name, input icache_pkg::inst_t got,
                              input icache_pkg::inst_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input icache_pkg::addr_t got,
                              input icache_pkg::addr_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        err_count++;
        $display("ERROR t=%0t %s", $time, msg);
    endtask

    task automatic finish_run();
        $display("tests 5, checks %0d, errors %0d, timeout %0d",
                 check_count, err_count, timed_out);
        if (err_count == 0 && !timed_out) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string msg);
        $display("ERROR t=%0t timeout, %s", $time, msg);
        timed_out = 1'b1;
        finish_run();
    endtask

    task automatic end_test(input int num, input string name, input int errs_before);
        $display("test %0d %s: %s", num, name, (err_count == errs_before) ? "PASS" : "FAIL");
    endtask

    function automatic logic model_holds(input icache_pkg::addr_t a);
        return (m_valid[0][a[8:3]] && m_tag[0][a[8:3]] == a[31:9])
            || (m_valid[1][a[8:3]] && m_tag[1][a[8:3]] == a[31:9]);
    endfunction

    // the victim is the first invalid way, way 0 before way 1, and else the older way.
    task automatic model_access(input icache_pkg::addr_t a, output logic miss);
        icache_pkg::index_t idx;
        icache_pkg::tag_t   t;
        icache_pkg::way_t   w;
        idx = a[8:3];
        t = a[31:9];
        miss = 1'b0;
        if (m_valid[0][idx] && m_tag[0][idx] == t) begin
            m_lru[idx] = 1'b1;
        end else if (m_valid[1][idx] && m_tag[1][idx] == t) begin
            m_lru[idx] = 1'b0;
        end else begin
            miss = 1'b1;
            if (!m_valid[0][idx]) begin
                w = 1'b0;
            end else if (!m_valid[1][idx]) begin
                w = 1'b1;
            end else begin
                w = m_lru[idx];
            end
            m_valid[w][idx] = 1'b1;
            m_tag[w][idx] = t;
            m_lru[idx] = ~w;
        end
    endtask

    task automatic wait_ready(input int limit);
        int n;
        n = 0;
        @(posedge clk);
        while (!ready_o) begin
            n++;
            if (n > limit) begin
                abort_on_timeout("ready_o stayed low");
            end
            @(posedge clk);
        end
    endtask

    task automatic fetch(input icache_pkg::addr_t addr, output logic missed);
        logic exp_miss;
        logic got_resp;
        int   n;
        int   mem_at;
        model_access(addr, exp_miss);
        wait_ready(RESP_LIMIT);
        req_valid_i <= 1'b1;
        req_addr_i <= addr;
        @(posedge clk);
        req_valid_i <= 1'b0;
        missed = 1'b0;
        got_resp = 1'b0;
        n = 0;
        mem_at = 0;
        while (!got_resp) begin
            @(posedge clk);
            n++;
            if (n > RESP_LIMIT) begin
                abort_on_timeout("no resp_valid_o for a fetch");
            end
            if (mem_req_o && !missed) begin
                missed = 1'b1;
                check_addr("mem_addr_o", mem_addr_o, {addr[31:3], 3'b000});
            end
            if (mem_resp_valid_i) begin
                mem_at = n;
            end
            got_resp = resp_valid_o;
        end
        check_flag("mem_req_o", missed, exp_miss);
        check_inst("resp_inst_o", resp_inst_o, mem_word({addr[31:2], 2'b00}));
        if (missed && (n - mem_at) != 3) begin
            report_error($sformatf("miss answered %0d cycles after memory data", n - mem_at));
        end
        if (!missed && n != 2) begin
            report_error($sformatf("hit answered %0d cycles after acceptance", n));
        end
        model_refills += int'(exp_miss);
    endtask

    task automatic fence_cache();
        int n;
        wait_ready(RESP_LIMIT);
        fence_i <= 1'b1;
        @(posedge clk);
        fence_i <= 1'b0;
        for (int s = 0; s < SETS; s++) begin
            m_valid[0][s] = 1'b0;
            m_valid[1][s] = 1'b0;
        end
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > SETS + 8) begin
                abort_on_timeout("ready_o did not return after a fence");
            end
        end while (!ready_o);
        if (n != SETS + 1) begin
            report_error($sformatf("fence walk held ready_o low for %0d cycles", n - 1));
        end
    endtask

    initial begin
        icache_pkg::addr_t addr;
        icache_pkg::addr_t cached [$];
        logic              missed;
        int                errs;
        int                r;
        int                op;
        rst_n_i = 1'b0;
        req_valid_i = 1'b0;
        req_addr_i = '0;
        fence_i = 1'b0;
        for (int s = 0; s < SETS; s++) begin
            m_valid[0][s] = 1'b0;
            m_valid[1][s] = 1'b0;
            m_lru[s] = 1'b0;
        end
        repeat (8) @(posedge clk);
        rst_n_i <= 1'b1;

        errs = err_count;
        wait_ready(SETS + 8);
        fetch(32'h0040_1a34, missed);
        check_flag("mem_req_o on first fetch", missed, 1'b1);
        end_test(1, "reset walk and first miss", errs);

        errs = err_count;
        fetch(32'h0040_1a34, missed);
        check_flag("mem_req_o on repeat fetch", missed, 1'b0);
        fetch(32'h0040_1a30, missed);
        check_flag("mem_req_o on other word", missed, 1'b0);
        end_test(2, "repeat fetch hits", errs);

        // three tags share set 0x15, so one of them is always out.
        errs = err_count;
        for (int i = 0; i < 11; i++) begin
            r = i;
            if (i >= 3) begin
                rand_bits(2, r);
            end
            fetch({icache_pkg::tag_t'(23'h0a5c3 + 23'h1111 * (r % 3)), 6'h15, 3'b100}, missed);
        end
        for (int i = 0; i < 3; i++) begin
            addr = {icache_pkg::tag_t'(23'h0a5c3 + 23'h1111 * i), 6'h15, 3'b000};
            if (!model_holds(addr)) begin
                fetch(addr, missed);
                check_flag("mem_req_o on evicted tag", missed, 1'b1);
            end
        end
        end_test(3, "victim order on one set", errs);

        errs = err_count;
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < 2; w++) begin
                if (m_valid[w][s]) begin
                    cached.push_back({m_tag[w][s], icache_pkg::index_t'(s), 3'b000});
                end
            end
        end
        fence_cache();
        foreach (cached[i]) begin
            fetch(cached[i], missed);
            check_flag("mem_req_o after fence", missed, 1'b1);
        end
        end_test(4, "fence invalidates all lines", errs);

        errs = err_count;
        dut_refills = 0;
        model_refills = 0;
        for (int i = 0; i < 300; i++) begin
            rand_bits(4, op);
            if (op == 0) begin
                fence_cache();
            end else begin
                rand_bits(2, r);
                repeat (r) @(posedge clk);
                rand_bits(3, r);
                mem_delay <= 1 + r % 6;
                rand_bits(2, op);
                rand_bits(2, r);
                addr = {icache_pkg::tag_t'(23'h01c0d + 23'h00fed * op),
                        icache_pkg::index_t'(6'h07 + 6'h0b * r), 3'b000};
                rand_bits(1, r);
                addr[2] = r[0];
                fetch(addr, missed);
            end
        end
        if (dut_refills != model_refills) begin
            report_error($sformatf("%0d refills seen, model expects %0d",
                                   dut_refills, model_refills));
        end
        end_test(5, "random fetch and fence mix", errs);
        finish_run();
    end

endmodule

`default_nettype wire

// File: vlog.f
verilog/icache_pkg.sv
verilog/icache_sram.sv
verilog/icache_lookup.sv
verilog/icache_replace.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
sim/icache_props.sv
sim/icache_tb.sv
